//--- hw/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
    input  rvCorePkg::aluOp            op,
    input  logic [rvCorePkg::xlen-1:0] a,
    input  logic [rvCorePkg::xlen-1:0] b,
    input  logic                       is32,
    output logic [rvCorePkg::xlen-1:0] result
);

    logic [5:0]                 shamt;
    logic [rvCorePkg::xlen-1:0] srlSrc;
    logic [rvCorePkg::xlen-1:0] sraSrc;

    // word shifts use 5 bits and the low word as source
    assign shamt  = is32 ? {1'b0, b[4:0]} : b[5:0];
    assign srlSrc = is32 ? {32'b0, a[31:0]} : a;
    assign sraSrc = is32 ? {{32{a[31]}}, a[31:0]} : a;

    always_comb begin
        case (op)
            rvCorePkg::aluAdd:   result = a + b;
            rvCorePkg::aluSub:   result = a - b;
            rvCorePkg::aluSll:   result = a << shamt;
            rvCorePkg::aluSlt:   result = {63'b0, $signed(a) < $signed(b)};
            rvCorePkg::aluSltu:  result = {63'b0, a < b};
            rvCorePkg::aluXor:   result = a ^ b;
            rvCorePkg::aluSrl:   result = srlSrc >> shamt;
            rvCorePkg::aluSra:   result = $signed(sraSrc) >>> shamt;
            rvCorePkg::aluOr:    result = a | b;
            rvCorePkg::aluAnd:   result = a & b;
            rvCorePkg::aluPassB: result = b;             // lui
            default:             result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/decodeExecTop.sv
`timescale 1ns/10ps
`default_nettype none

module decodeExecTop (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       inValid,
    output logic                       inReady,
    input  rvCorePkg::instWord         inst,
    input  logic [rvCorePkg::xlen-1:0] pc,
    input  logic [rvCorePkg::xlen-1:0] rs1Data,
    input  logic [rvCorePkg::xlen-1:0] rs2Data,
    output logic                       outValid,
    input  logic                       outReady,
    output logic [4:0]                 rdAddr,
    output logic                       writeRd,
    output logic [rvCorePkg::xlen-1:0] rdData,
    output logic                       redirect,
    output logic [rvCorePkg::xlen-1:0] redirectPc,
    output logic [rvCorePkg::xlen-1:0] memAddr,
    output logic [rvCorePkg::xlen-1:0] storeData,
    output logic [7:0]                 storeMask,
    output logic                       loadEn,
    output logic [3:0]                 loadBytes,
    output logic                       loadSigned
);

    logic decValid, decReady, selA, selB, decWriteRd, isBranch, isJal, isJalr;
    logic decLoadEn, decLoadSigned;
    logic [4:0] decRdAddr;
    logic [2:0] branchFunct3;
    logic [7:0] decStoreMask;
    logic [3:0] decLoadBytes;
    logic [rvCorePkg::xlen-1:0] imm, decPc, decRs1Data, decRs2Data;
    rvCorePkg::aluOp aluOperate;
    rvCorePkg::wbSel wbSelect;

    instDecoder u_instDecoder (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady), .inst(inst),
        .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .decValid(decValid), .decReady(decReady), .aluOperate(aluOperate),
        .selA(selA), .selB(selB), .imm(imm), .wbSelect(wbSelect),
        .writeRd(decWriteRd), .rdAddr(decRdAddr), .isBranch(isBranch),
        .branchFunct3(branchFunct3), .isJal(isJal), .isJalr(isJalr),
        .storeMask(decStoreMask), .loadEn(decLoadEn), .loadBytes(decLoadBytes),
        .loadSigned(decLoadSigned), .decPc(decPc), .decRs1Data(decRs1Data),
        .decRs2Data(decRs2Data)
    );

    executeStage u_executeStage (
        .clk(clk), .rstN(rstN), .decValid(decValid), .decReady(decReady),
        .aluOperate(aluOperate), .selA(selA), .selB(selB), .imm(imm),
        .wbSelect(wbSelect), .decWriteRd(decWriteRd), .decRdAddr(decRdAddr),
        .isBranch(isBranch), .branchFunct3(branchFunct3), .isJal(isJal),
        .isJalr(isJalr), .decStoreMask(decStoreMask), .decLoadEn(decLoadEn),
        .decLoadBytes(decLoadBytes), .decLoadSigned(decLoadSigned),
        .pc(decPc), .rs1Data(decRs1Data), .rs2Data(decRs2Data),
        .outValid(outValid), .outReady(outReady), .rdAddr(rdAddr),
        .writeRd(writeRd), .rdData(rdData), .redirect(redirect),
        .redirectPc(redirectPc), .memAddr(memAddr), .storeData(storeData),
        .storeMask(storeMask), .loadEn(loadEn), .loadBytes(loadBytes),
        .loadSigned(loadSigned)
    );

endmodule

`default_nettype wire

//--- hw/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       decValid,
    output logic                       decReady,
    input  rvCorePkg::aluOp            aluOperate,
    input  logic                       selA,
    input  logic                       selB,
    input  logic [rvCorePkg::xlen-1:0] imm,
    input  rvCorePkg::wbSel            wbSelect,
    input  logic                       decWriteRd,
    input  logic [4:0]                 decRdAddr,
    input  logic                       isBranch,
    input  logic [2:0]                 branchFunct3,
    input  logic                       isJal,
    input  logic                       isJalr,
    input  logic [7:0]                 decStoreMask,
    input  logic                       decLoadEn,
    input  logic [3:0]                 decLoadBytes,
    input  logic                       decLoadSigned,
    input  logic [rvCorePkg::xlen-1:0] pc,
    input  logic [rvCorePkg::xlen-1:0] rs1Data,
    input  logic [rvCorePkg::xlen-1:0] rs2Data,
    output logic                       outValid,
    input  logic                       outReady,
    output logic [4:0]                 rdAddr,
    output logic                       writeRd,
    output logic [rvCorePkg::xlen-1:0] rdData,
    output logic                       redirect,
    output logic [rvCorePkg::xlen-1:0] redirectPc,
    output logic [rvCorePkg::xlen-1:0] memAddr,
    output logic [rvCorePkg::xlen-1:0] storeData,
    output logic [7:0]                 storeMask,
    output logic                       loadEn,
    output logic [3:0]                 loadBytes,
    output logic                       loadSigned
);

    logic [rvCorePkg::xlen-1:0] opA, opB, aluRes, pcPlus4, rs1PlusImm, nRdData;
    logic taken;

    assign decReady   = !outValid || outReady;
    assign opA        = selA ? rs1Data : pc;
    assign opB        = selB ? rs2Data : imm;
    assign pcPlus4    = pc + 64'd4;
    assign rs1PlusImm = rs1Data + imm;           // load/store address and jalr target

    aluUnit u_aluUnit (
        .op(aluOperate), .a(opA), .b(opB),
        .is32(wbSelect == rvCorePkg::wbAluRes32), .result(aluRes)
    );

    always_comb begin
        case (branchFunct3)
            3'b000:  taken = rs1Data == rs2Data;
            3'b001:  taken = rs1Data != rs2Data;
            3'b100:  taken = $signed(rs1Data) < $signed(rs2Data);
            3'b101:  taken = $signed(rs1Data) >= $signed(rs2Data);
            3'b110:  taken = rs1Data < rs2Data;
            3'b111:  taken = rs1Data >= rs2Data;
            default: taken = 1'b0;               // reserved encodings
        endcase
        case (wbSelect)
            rvCorePkg::wbAluRes32: nRdData = {{32{aluRes[31]}}, aluRes[31:0]};
            rvCorePkg::wbPcPlus4:  nRdData = pcPlus4;
            default:               nRdData = aluRes;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            {writeRd, redirect, loadEn} <= '0;
            storeMask <= 8'h00;
        end else if (decReady) begin
            outValid <= decValid;
            if (decValid) begin
                writeRd   <= decWriteRd;
                redirect  <= (isBranch && taken) || isJal || isJalr;
                loadEn    <= decLoadEn;
                storeMask <= decStoreMask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decValid && decReady) begin
            rdAddr     <= decRdAddr;
            rdData     <= nRdData;
            redirectPc <= isJalr ? {rs1PlusImm[63:1], 1'b0} : pc + imm;
            memAddr    <= rs1PlusImm;
            storeData  <= rs2Data;
            loadBytes  <= decLoadBytes;
            loadSigned <= decLoadSigned;
        end
    end

    // stalled output must hold every field
    assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable({rdAddr, writeRd, rdData, redirect,
            redirectPc, memAddr, storeData, storeMask, loadEn, loadBytes, loadSigned}));

endmodule

`default_nettype wire

//--- hw/immGen.sv
`timescale 1ns/10ps
`default_nettype none

module immGen (
    input  rvCorePkg::instWord         inst,
    output logic [rvCorePkg::xlen-1:0] imm
);

    always_comb begin
        case (inst.r.opcode)
            rvCorePkg::opImm,
            rvCorePkg::opImm32,
            rvCorePkg::opLoad,
            rvCorePkg::opJalr: begin
                imm = {{52{inst.i.imm[11]}}, inst.i.imm}; // shamt kept raw
            end
            rvCorePkg::opStore: begin
                imm = {{52{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
            end
            rvCorePkg::opBranch: begin
                imm = {{51{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.immHi, inst.b.immLo, 1'b0};
            end
            rvCorePkg::opLui,
            rvCorePkg::opAuipc: begin
                imm = {{32{inst.u.imm[19]}}, inst.u.imm, 12'b0};
            end
            rvCorePkg::opJal: begin
                imm = {{43{inst.j.imm20}}, inst.j.imm20, inst.j.immHi,
                       inst.j.imm11, inst.j.immLo, 1'b0};
            end
            default: begin
                imm = '0;                               // no immediate
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/instDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instDecoder (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       inValid,
    output logic                       inReady,
    input  rvCorePkg::instWord         inst,
    input  logic [rvCorePkg::xlen-1:0] pc,
    input  logic [rvCorePkg::xlen-1:0] rs1Data,
    input  logic [rvCorePkg::xlen-1:0] rs2Data,
    output logic                       decValid,
    input  logic                       decReady,
    output rvCorePkg::aluOp            aluOperate,
    output logic                       selA,         // 1 rs1, 0 pc
    output logic                       selB,         // 1 rs2, 0 imm
    output logic [rvCorePkg::xlen-1:0] imm,
    output rvCorePkg::wbSel            wbSelect,
    output logic                       writeRd,
    output logic [4:0]                 rdAddr,
    output logic                       isBranch,
    output logic [2:0]                 branchFunct3,
    output logic                       isJal,
    output logic                       isJalr,
    output logic [7:0]                 storeMask,
    output logic                       loadEn,
    output logic [3:0]                 loadBytes,
    output logic                       loadSigned,
    output logic [rvCorePkg::xlen-1:0] decPc,
    output logic [rvCorePkg::xlen-1:0] decRs1Data,
    output logic [rvCorePkg::xlen-1:0] decRs2Data
);

    logic [rvCorePkg::xlen-1:0] immVal;
    rvCorePkg::aluOp nAluOp;
    rvCorePkg::wbSel nWbSel;
    logic       nSelA, nSelB, nWriteRd, nIsBranch, nIsJal, nIsJalr, nLoadEn;
    logic [7:0] nStoreMask;
    logic [2:0] f3;
    logic [6:0] f7;

    immGen u_immGen (.inst(inst), .imm(immVal));

    assign f3      = inst.r.funct3;
    assign f7      = inst.r.funct7;
    assign inReady = !decValid || decReady;

    always_comb begin
        nAluOp = rvCorePkg::aluNone;
        nWbSel = rvCorePkg::wbAluRes;
        {nSelA, nSelB, nWriteRd, nIsBranch, nIsJal, nIsJalr, nLoadEn} = '0;
        nStoreMask = 8'h00;
        case (inst.r.opcode)
            rvCorePkg::opReg, rvCorePkg::opReg32, rvCorePkg::opImm, rvCorePkg::opImm32: begin
                nSelA    = 1'b1;
                nSelB    = inst.r.opcode[5];              // register forms use rs2
                nWriteRd = 1'b1;
                if (inst.r.opcode[3]) nWbSel = rvCorePkg::wbAluRes32;
                case (f3)
                    3'b000: nAluOp = (inst.r.opcode[5] && f7 == 7'h20) ? rvCorePkg::aluSub
                                   : (!inst.r.opcode[5] || f7 == 7'h00) ? rvCorePkg::aluAdd
                                   : rvCorePkg::aluNone;
                    3'b001: nAluOp = rvCorePkg::aluSll;
                    3'b101: begin
                        if (f7[6:1] == 6'h10) nAluOp = rvCorePkg::aluSra;  // funct7[0] is shamt[5]
                        else if (f7[6:1] == 6'h00) nAluOp = rvCorePkg::aluSrl;
                    end
                    default: begin
                        if (!inst.r.opcode[3]) begin                   // 64-bit only
                            case (f3)
                                3'b010:  nAluOp = rvCorePkg::aluSlt;
                                3'b011:  nAluOp = rvCorePkg::aluSltu;
                                3'b100:  nAluOp = rvCorePkg::aluXor;
                                3'b110:  nAluOp = rvCorePkg::aluOr;
                                default: nAluOp = rvCorePkg::aluAnd;
                            endcase
                        end
                    end
                endcase
            end
            rvCorePkg::opLui: begin
                nAluOp   = rvCorePkg::aluPassB;
                nWriteRd = 1'b1;
            end
            rvCorePkg::opAuipc: begin
                nAluOp   = rvCorePkg::aluAdd;             // pc + imm
                nWriteRd = 1'b1;
            end
            rvCorePkg::opJal, rvCorePkg::opJalr: begin
                nWbSel   = rvCorePkg::wbPcPlus4;
                nWriteRd = 1'b1;
                nIsJal   = inst.r.opcode[3];
                nIsJalr  = !inst.r.opcode[3];
            end
            rvCorePkg::opBranch: nIsBranch = 1'b1;
            rvCorePkg::opLoad:   nLoadEn = (f3 != 3'b111);    // rd written by memory side
            rvCorePkg::opStore: begin
                case (f3)
                    3'b000:  nStoreMask = 8'h01;
                    3'b001:  nStoreMask = 8'h03;
                    3'b010:  nStoreMask = 8'h0f;
                    3'b011:  nStoreMask = 8'hff;
                    default: nStoreMask = 8'h00;
                endcase
            end
            default: ;                                     // bubble
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
            {writeRd, isBranch, isJal, isJalr, loadEn} <= '0;
            storeMask <= 8'h00;
        end else if (inReady) begin
            decValid <= inValid;
            if (inValid) begin
                {writeRd, isBranch, isJal, isJalr, loadEn} <=
                    {nWriteRd, nIsBranch, nIsJal, nIsJalr, nLoadEn};
                storeMask <= nStoreMask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            aluOperate   <= nAluOp;
            wbSelect     <= nWbSel;
            {selA, selB} <= {nSelA, nSelB};
            imm          <= immVal;
            rdAddr       <= inst.r.rd;
            branchFunct3 <= f3;
            loadBytes    <= 4'd1 << f3[1:0];             // 1, 2, 4 or 8 bytes
            loadSigned   <= !f3[2];
            decPc        <= pc;
            decRs1Data   <= rs1Data;
            decRs2Data   <= rs2Data;
        end
    end

    // mask legal and covering exactly the access size
    assert property (@(posedge clk) disable iff (!rstN)
        decValid |-> storeMask inside {8'h00, 8'h01, 8'h03, 8'h0f, 8'hff} &&
            (storeMask == 8'h00 || storeMask == ~(8'hff << loadBytes)));

endmodule

`default_nettype wire

//--- hw/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

    localparam int xlen = 64;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10,
        aluNone  = 4'd15      // result forced to zero
    } aluOp;

    typedef enum logic [1:0] {
        wbAluRes   = 2'd0,
        wbAluRes32 = 2'd1,    // low word, sign-extended
        wbPcPlus4  = 2'd2     // link value
    } wbSel;

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opImm32  = 7'b0011011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opReg32  = 7'b0111011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opJal    = 7'b1101111;

    typedef struct packed {
        logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
    } rFormat;

    typedef struct packed {
        logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
        logic [4:0] rd; logic [6:0] opcode;
    } iFormat;

    typedef struct packed {
        logic [6:0] immHi; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] immLo; logic [6:0] opcode;
    } sFormat;

    typedef struct packed {
        logic imm12; logic [5:0] immHi; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [3:0] immLo; logic imm11; logic [6:0] opcode;
    } bFormat;

    typedef struct packed {
        logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;
    } uFormat;

    typedef struct packed {
        logic imm20; logic [9:0] immLo; logic imm11; logic [7:0] immHi;
        logic [4:0] rd; logic [6:0] opcode;
    } jFormat;

    // one instruction word, six views
    typedef union packed {
        rFormat r;
        iFormat i;
        sFormat s;
        bFormat b;
        uFormat u;
        jFormat j;
    } instWord;

endpackage

`default_nettype wire

//--- sim/rvRefModel.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

typedef struct packed {
    logic [31:0] word;
    logic        writeRd;
    logic [4:0]  rdAddr;
    logic [63:0] rdData;
    logic        redirect;
    logic [63:0] redirectPc;
    logic        memOp;           // load or store, memAddr valid
    logic [63:0] memAddr;
    logic [63:0] storeData;
    logic [7:0]  storeMask;
    logic        loadEn;
    logic [3:0]  loadBytes;
    logic        loadSigned;
    logic        timed;           // accepted without stalls
    logic [31:0] acceptCycle;
} expRec;

// taps 32 22 2 1
function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [63:0] randBits(input int n);
    logic [63:0] r;
    int          k;
    r = '0;
    for (k = 0; k < n; k++) begin
        lfsrState = nextLfsr(lfsrState);
        r = {r[62:0], lfsrState[0]};
    end
    return r;
endfunction

// legal encodings only, plus fence as an unsupported opcode
function automatic logic [31:0] genInst();
    logic [4:0]  rd;
    logic [4:0]  r1;
    logic [4:0]  r2;
    logic [2:0]  f3;
    logic [11:0] i12;
    logic [3:0]  cls;
    logic        alt;
    logic [6:0]  f7;
    rd  = 5'(randBits(5));
    r1  = 5'(randBits(5));
    r2  = 5'(randBits(5));
    f3  = 3'(randBits(3));
    i12 = 12'(randBits(12));
    alt = 1'(randBits(1));
    cls = 4'(randBits(4));
    if (cls == 4'd6 || cls == 4'd7) f3 = f3[1] ? 3'b101 : {2'b00, f3[0]};  // word forms
    f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
    case (cls)
        4'd0, 4'd1, 4'd2: return {f7, r2, r1, f3, rd, rvCorePkg::opReg};
        4'd6: return {f7, r2, r1, f3, rd, rvCorePkg::opReg32};
        4'd3, 4'd4, 4'd5: begin
            if (f3 == 3'b001) i12 = {6'h00, i12[5:0]};
            if (f3 == 3'b101) i12 = {1'b0, alt, 4'h0, i12[5:0]};  // srli or srai
            return {i12, r1, f3, rd, rvCorePkg::opImm};
        end
        4'd7: begin
            if (f3 != 3'b000) i12 = {1'b0, alt && f3[2], 5'h00, i12[4:0]};
            return {i12, r1, f3, rd, rvCorePkg::opImm32};
        end
        4'd8: return {i12, r1, f3, rd, rvCorePkg::opLui};
        4'd9: return {i12, r1, f3, rd, rvCorePkg::opAuipc};
        4'd10: return {i12, r1, f3, rd, rvCorePkg::opJal};
        4'd11: return {i12, r1, 3'b000, rd, rvCorePkg::opJalr};
        4'd12, 4'd13: begin
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;                   // skip reserved 010, 011
            return {i12[11:5], r2, r1, f3, i12[4:0], rvCorePkg::opBranch};
        end
        4'd14: return {i12, r1, (f3 == 3'b111) ? 3'b011 : f3, rd, rvCorePkg::opLoad};
        default: begin
            if (alt) return {i12, r1, 3'b000, rd, 7'b0001111};     // fence
            return {i12[11:5], r2, r1, 1'b0, f3[1:0], i12[4:0], rvCorePkg::opStore};
        end
    endcase
endfunction

// expected outputs from the RV64I rules
function automatic expRec refModel(input logic [31:0] w, input logic [63:0] pcVal, a, b);
    expRec       e;
    logic [63:0] iImm;
    logic [63:0] opnd;
    logic [63:0] r;
    logic [5:0]  sh;
    logic [2:0]  f3;
    logic [3:0]  nBytes;
    f3       = w[14:12];
    iImm     = {{52{w[31]}}, w[31:20]};
    nBytes   = 4'd1 << f3[1:0];
    e        = '0;
    e.word   = w;
    e.rdAddr = w[11:7];
    case (w[6:0])
        rvCorePkg::opReg, rvCorePkg::opImm, rvCorePkg::opReg32, rvCorePkg::opImm32: begin
            opnd = w[5] ? b : iImm;                     // register or immediate form
            sh   = w[3] ? {1'b0, opnd[4:0]} : opnd[5:0];
            case (f3)
                3'd0: r = (w[5] && w[30]) ? a - opnd : a + opnd;
                3'd1: r = a << sh;
                3'd2: r = {63'b0, $signed(a) < $signed(opnd)};
                3'd3: r = {63'b0, a < opnd};
                3'd4: r = a ^ opnd;
                3'd5: begin
                    if (w[3] && w[30]) r = $signed({{32{a[31]}}, a[31:0]}) >>> sh;
                    else if (w[3]) r = {32'b0, a[31:0]} >> sh;
                    else if (w[30]) r = $signed(a) >>> sh;
                    else r = a >> sh;
                end
                3'd6: r = a | opnd;
                default: r = a & opnd;
            endcase
            e.writeRd = 1'b1;
            e.rdData  = w[3] ? {{32{r[31]}}, r[31:0]} : r;
        end
        rvCorePkg::opLui: begin
            e.writeRd = 1'b1;
            e.rdData  = {{32{w[31]}}, w[31:12], 12'b0};
        end
        rvCorePkg::opAuipc: begin
            e.writeRd = 1'b1;
            e.rdData  = pcVal + {{32{w[31]}}, w[31:12], 12'b0};
        end
        rvCorePkg::opJal: begin
            e.writeRd    = 1'b1;
            e.rdData     = pcVal + 64'd4;
            e.redirect   = 1'b1;
            e.redirectPc = pcVal + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        rvCorePkg::opJalr: begin
            e.writeRd    = 1'b1;
            e.rdData     = pcVal + 64'd4;
            e.redirect   = 1'b1;
            e.redirectPc = (a + iImm) & ~64'd1;
        end
        rvCorePkg::opBranch: begin
            case (f3)
                3'd0: e.redirect = a == b;
                3'd1: e.redirect = a != b;
                3'd4: e.redirect = $signed(a) < $signed(b);
                3'd5: e.redirect = $signed(a) >= $signed(b);
                3'd6: e.redirect = a < b;
                default: e.redirect = a >= b;
            endcase
            e.redirectPc = pcVal + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        rvCorePkg::opLoad: begin
            e.memOp      = 1'b1;
            e.memAddr    = a + iImm;
            e.loadEn     = 1'b1;
            e.loadBytes  = nBytes;
            e.loadSigned = !f3[2];
        end
        rvCorePkg::opStore: begin
            e.memOp     = 1'b1;
            e.memAddr   = a + {{52{w[31]}}, w[31:25], w[11:7]};
            e.storeData = b;
            e.storeMask = ~(8'hff << nBytes);
        end
        default: ;                                          // bubble
    endcase
    return e;
endfunction

`endif

//--- sim/tbDecodeExec.sv
`timescale 1ns/10ps
`default_nettype none

module tbDecodeExec;

    localparam int numPlain   = 100;                  // no stalls, latency checked
    localparam int numStalled = 300;
    localparam int cycleLimit = 4 * (numPlain + numStalled) + 100;

    logic        clk;
    logic        rstN;
    logic        inValid;
    logic        inReady;
    logic [31:0] inst;
    logic [63:0] pc;
    logic [63:0] rs1Data;
    logic [63:0] rs2Data;
    logic        outValid;
    logic        outReady;
    logic [4:0]  rdAddr;
    logic        writeRd;
    logic [63:0] rdData;
    logic        redirect;
    logic [63:0] redirectPc;
    logic [63:0] memAddr;
    logic [63:0] storeData;
    logic [7:0]  storeMask;
    logic        loadEn;
    logic [3:0]  loadBytes;
    logic        loadSigned;
    logic [31:0] lfsrState;
    logic        stallMode;
    int          cycleCount;
    int          errorCount;
    int          checkCount;

    `include "rvRefModel.svh"

    expRec expQ[$];
    expRec accRec;
    expRec outRec;

    decodeExecTop i_decodeExecTop (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady), .inst(inst),
        .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .outValid(outValid),
        .outReady(outReady), .rdAddr(rdAddr), .writeRd(writeRd), .rdData(rdData),
        .redirect(redirect), .redirectPc(redirectPc), .memAddr(memAddr),
        .storeData(storeData), .storeMask(storeMask), .loadEn(loadEn),
        .loadBytes(loadBytes), .loadSigned(loadSigned)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compareValue(input string testName, input logic [63:0] expected,
                                input logic [63:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Mismatch %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkRecord(input expRec e);
        string tag;
        tag = $sformatf("inst %08h", e.word);
        compareValue({tag, " writeRd"}, e.writeRd, writeRd);
        compareValue({tag, " redirect"}, e.redirect, redirect);
        compareValue({tag, " storeMask"}, e.storeMask, storeMask);
        compareValue({tag, " loadEn"}, e.loadEn, loadEn);
        if (e.writeRd) begin
            compareValue({tag, " rdAddr"}, e.rdAddr, rdAddr);
            compareValue({tag, " rdData"}, e.rdData, rdData);
        end
        if (e.redirect) compareValue({tag, " redirectPc"}, e.redirectPc, redirectPc);
        if (e.memOp) compareValue({tag, " memAddr"}, e.memAddr, memAddr);
        if (e.storeMask != 8'h00) compareValue({tag, " storeData"}, e.storeData, storeData);
        if (e.loadEn) begin
            compareValue({tag, " loadBytes"}, e.loadBytes, loadBytes);
            compareValue({tag, " loadSigned"}, e.loadSigned, loadSigned);
        end
        if (e.timed) compareValue({tag, " latency"}, 64'd2, 64'(cycleCount - e.acceptCycle));
    endtask

    // one clock, reports whether the input transferred at this edge
    task automatic stepCycle(output logic accepted);
        @(posedge clk);
        accepted = inValid && inReady;
        #2;
        outReady = stallMode ? (randBits(2) != 0) : 1'b1;  // roughly one stall in four
    endtask

    task automatic sendInst();
        logic acc;
        inst    = genInst();
        rs1Data = randBits(64);
        rs2Data = (randBits(2) == 0) ? rs1Data : randBits(64);  // equal operands now and then
        pc      = randBits(64) & ~64'd3;
        inValid = 1'b1;
        acc     = 1'b0;
        while (!acc) stepCycle(acc);
        inValid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, %0d results still pending", cycleCount,
                     expQ.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (rstN && inValid && inReady) begin
            accRec             = refModel(inst, pc, rs1Data, rs2Data);
            accRec.timed       = !stallMode;
            accRec.acceptCycle = cycleCount;
            expQ.push_back(accRec);
        end
    end

    always @(posedge clk) begin
        if (rstN && outValid && outReady) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("output transfer seen with no instruction pending");
            end else begin
                outRec = expQ.pop_front();
                checkRecord(outRec);
            end
        end
    end

    initial begin
        logic acc;
        int   drainSteps;
        rstN      = 1'b0;
        inValid   = 1'b0;
        inst      = '0;
        pc        = '0;
        rs1Data   = '0;
        rs2Data   = '0;
        outReady  = 1'b1;
        stallMode = 1'b0;
        lfsrState = 32'h0ae8c87f;
        repeat (3) @(posedge clk);
        #2;
        rstN = 1'b1;
        repeat (numPlain) sendInst();                   // back to back, no stalls
        repeat (3) stepCycle(acc);
        stallMode = 1'b1;
        repeat (numStalled) begin
            if (randBits(1) != 0) repeat (randBits(2)) stepCycle(acc);  // input gap
            sendInst();
        end
        stallMode  = 1'b0;
        drainSteps = 0;
        while (expQ.size() != 0 && drainSteps < 8) begin  // both stages empty out
            stepCycle(acc);
            drainSteps++;
        end
        repeat (2) stepCycle(acc);                      // watch for stray outputs
        if (expQ.size() != 0) begin
            errorCount++;
            $display("%0d accepted instructions never came out", expQ.size());
        end
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+sim
hw/rvCorePkg.sv
hw/immGen.sv
hw/aluUnit.sv
hw/instDecoder.sv
hw/executeStage.sv
hw/decodeExecTop.sv
sim/tbDecodeExec.sv
